// File: exec_pkg.sv
package exec_pkg;

    localparam int XLEN       = 32;
    localparam int BOOTH_ROWS = XLEN / 2;   // One partial product per radix-4 digit
    localparam int PIPE_DEPTH = 3;          // Issue to result, in cycles

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      shamt_t;

    // Operation codes as the core's decoder produces them
    typedef enum logic [3:0] {
        ADD = 4'd0,
        SLL = 4'd1,
        SLT = 4'd2,
        SUB = 4'd3,
        XOR = 4'd4,
        SRL = 4'd5,
        OR  = 4'd6,
        AND = 4'd7,
        SRA = 4'd8
    } alu_op_t;

    // One row of the carry-save tree, cut to the low product bits
    typedef logic [XLEN-1:0] row_t;

endpackage

// File: alu.sv
`timescale 1ns/10ps

module alu (
    input  exec_pkg::alu_op_t op,
    input  exec_pkg::word_t   a,
    input  exec_pkg::word_t   b,
    output exec_pkg::word_t   y
);

    logic [exec_pkg::XLEN:0] diff;    // Extra bit holds the true sign of a - b
    exec_pkg::shamt_t        shamt;

    assign shamt = b[4:0];   // Upper bits of b are ignored for shifts

    // Shared subtractor for SUB and SLT
    assign diff = {a[exec_pkg::XLEN-1], a} - {b[exec_pkg::XLEN-1], b};

    always_comb begin
        case (op)
            exec_pkg::ADD: y = a + b;
            exec_pkg::SUB: y = diff[exec_pkg::XLEN-1:0];
            exec_pkg::SLT: y = {{(exec_pkg::XLEN-1){1'b0}}, diff[exec_pkg::XLEN]};
            exec_pkg::SLL: y = a << shamt;
            exec_pkg::SRL: y = a >> shamt;
            exec_pkg::SRA: y = $signed(a) >>> shamt;   // Fills with a's sign
            exec_pkg::XOR: y = a ^ b;
            exec_pkg::OR:  y = a | b;
            default:       y = a & b;   // AND, and any undefined code
        endcase
    end

endmodule

// File: booth_encoder.sv
`timescale 1ns/10ps

module booth_encoder (
    input  exec_pkg::word_t a,
    input  exec_pkg::word_t b,
    output exec_pkg::row_t  rows [exec_pkg::BOOTH_ROWS]
);

    // Implicit zero below bit 0 for the first group
    logic [exec_pkg::XLEN:0] b_ext;

    assign b_ext = {b, 1'b0};

    always_comb begin
        logic [2:0]      grp;
        exec_pkg::word_t pp;
        for (int i = 0; i < exec_pkg::BOOTH_ROWS; i++) begin
            grp = b_ext[2*i +: 3];   // b[2i+1], b[2i], b[2i-1]
            case (grp)
                3'b001,
                3'b010:  pp = a;
                3'b011:  pp = a << 1;
                3'b100:  pp = ~(a << 1) + 1'b1;
                3'b101,
                3'b110:  pp = ~a + 1'b1;
                default: pp = '0;   // 000 and 111
            endcase
            // Sign bits above XLEN would be shifted out anyway
            rows[i] = pp << (2 * i);
        end
    end

endmodule

// File: csa_layer.sv
`timescale 1ns/10ps

module csa_layer #(
    parameter int ROWS_IN = 3
) (
    input  exec_pkg::row_t rows_in  [ROWS_IN],
    output exec_pkg::row_t rows_out [ROWS_IN - ROWS_IN / 3]
);

    // Each full group of three rows becomes a sum row and a carry row
    for (genvar g = 0; g < ROWS_IN / 3; g++) begin : g_fa
        exec_pkg::row_t x;
        exec_pkg::row_t y;
        exec_pkg::row_t z;
        exec_pkg::row_t maj;

        assign x   = rows_in[3*g];
        assign y   = rows_in[3*g + 1];
        assign z   = rows_in[3*g + 2];
        assign maj = (x & y) | (x & z) | (y & z);

        assign rows_out[2*g]     = x ^ y ^ z;
        assign rows_out[2*g + 1] = maj << 1;   // Top carry is dropped
    end

    // Leftover rows go to the next layer untouched
    for (genvar r = 0; r < ROWS_IN % 3; r++) begin : g_pass
        assign rows_out[2*(ROWS_IN / 3) + r] = rows_in[3*(ROWS_IN / 3) + r];
    end

endmodule

// File: booth_multiplier.sv
`timescale 1ns/10ps

module booth_multiplier (
    input  logic            clk,
    input  logic            RST_n,
    input  logic            stall,
    input  exec_pkg::word_t a,
    input  exec_pkg::word_t b,
    output exec_pkg::word_t product
);

    // Row counts per layer go 16, 11, 8, 6, 4, 3, 2
    exec_pkg::row_t pp_rows [exec_pkg::BOOTH_ROWS];
    exec_pkg::row_t l1_rows [11];
    exec_pkg::row_t l2_rows [8];
    exec_pkg::row_t s1_q    [8];    // First pipeline register
    exec_pkg::row_t l3_rows [6];
    exec_pkg::row_t l4_rows [4];
    exec_pkg::row_t s2_q    [4];    // Second pipeline register
    exec_pkg::row_t l5_rows [3];
    exec_pkg::row_t l6_rows [2];

    booth_encoder u_enc (
        .a    (a),
        .b    (b),
        .rows (pp_rows)
    );

    csa_layer #(.ROWS_IN(exec_pkg::BOOTH_ROWS)) u_l1 (
        .rows_in  (pp_rows),
        .rows_out (l1_rows)
    );

    csa_layer #(.ROWS_IN(11)) u_l2 (
        .rows_in  (l1_rows),
        .rows_out (l2_rows)
    );

    csa_layer #(.ROWS_IN(8)) u_l3 (
        .rows_in  (s1_q),
        .rows_out (l3_rows)
    );

    csa_layer #(.ROWS_IN(6)) u_l4 (
        .rows_in  (l3_rows),
        .rows_out (l4_rows)
    );

    csa_layer #(.ROWS_IN(4)) u_l5 (
        .rows_in  (s2_q),
        .rows_out (l5_rows)
    );

    csa_layer #(.ROWS_IN(3)) u_l6 (
        .rows_in  (l5_rows),
        .rows_out (l6_rows)
    );

    // Both banks freeze together with the rest of the pipeline
    always_ff @(posedge clk) begin
        if (!RST_n) begin
            s1_q <= '{default: '0};
            s2_q <= '{default: '0};
        end else if (!stall) begin
            s1_q <= l2_rows;
            s2_q <= l4_rows;
        end
    end

    // Final carry-propagate adder on the last two rows
    assign product = l6_rows[0] + l6_rows[1];

endmodule

// File: exec_unit.sv
`timescale 1ns/10ps

module exec_unit (
    input  logic              clk,
    input  logic              RST_n,
    input  logic              in_valid,
    input  exec_pkg::alu_op_t op,
    input  logic              is_mul,
    input  exec_pkg::word_t   a,
    input  exec_pkg::word_t   b,
    input  logic              stall,
    output logic              out_valid,
    output exec_pkg::word_t   result
);

    // Issue stage operands
    exec_pkg::alu_op_t op_q;
    exec_pkg::word_t   a_q;
    exec_pkg::word_t   b_q;

    // Index 0 is the issue stage and the last index feeds the output register
    logic [exec_pkg::PIPE_DEPTH-1:0] valid_q;
    logic [exec_pkg::PIPE_DEPTH-1:0] mul_q;

    exec_pkg::word_t alu_y;
    exec_pkg::word_t alu_q [exec_pkg::PIPE_DEPTH-1];   // In step with the multiplier banks
    exec_pkg::word_t product;

    always_ff @(posedge clk) begin
        if (!stall) begin
            op_q <= op;
            a_q  <= a;
            b_q  <= b;
        end
    end

    alu u_alu (
        .op (op_q),
        .a  (a_q),
        .b  (b_q),
        .y  (alu_y)
    );

    booth_multiplier u_mul (
        .clk     (clk),
        .RST_n   (RST_n),
        .stall   (stall),
        .a       (a_q),
        .b       (b_q),
        .product (product)
    );

    // Valid and select flags shift one stage per unstalled edge
    always_ff @(posedge clk) begin
        if (!RST_n) begin
            valid_q <= '0;
            mul_q   <= '0;
        end else if (!stall) begin
            valid_q <= {valid_q[exec_pkg::PIPE_DEPTH-2:0], in_valid};
            mul_q   <= {mul_q[exec_pkg::PIPE_DEPTH-2:0], is_mul};
        end
    end

    // ALU result waits while the product runs through the tree
    always_ff @(posedge clk) begin
        if (!stall) begin
            alu_q[0] <= alu_y;
            for (int i = 1; i < exec_pkg::PIPE_DEPTH - 1; i++) begin
                alu_q[i] <= alu_q[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!RST_n) begin
            out_valid <= 1'b0;
            result    <= '0;
        end else if (!stall) begin
            out_valid <= valid_q[exec_pkg::PIPE_DEPTH-1];
            if (valid_q[exec_pkg::PIPE_DEPTH-1]) begin   // Bubbles leave result alone
                result <= mul_q[exec_pkg::PIPE_DEPTH-1] ? product
                                                        : alu_q[exec_pkg::PIPE_DEPTH-2];
            end
        end
    end

endmodule

// File: exec_unit_tb.sv
`timescale 1ns/10ps

module exec_unit_tb;

    localparam int DRAIN_LIMIT = 40;   // Cycles allowed for the pipeline to empty

    logic              clk;
    logic              RST_n;
    logic              in_valid;
    exec_pkg::alu_op_t op;
    logic              is_mul;
    exec_pkg::word_t   a;
    exec_pkg::word_t   b;
    logic              stall;
    logic              out_valid;
    exec_pkg::word_t   result;

    // Three queues that move together hold the expected results in issue order
    string             name_q  [$];
    exec_pkg::word_t   value_q [$];
    int unsigned       edge_q  [$];

    string             cur_test;
    int unsigned       live_edges;     // Unstalled edges since reset
    logic              edge_seen;
    logic              edge_stalled;
    logic              prev_valid;
    exec_pkg::word_t   prev_result;
    int unsigned       checks;
    int unsigned       value_errors;
    int unsigned       other_errors;

    exec_unit uut (
        .clk       (clk),
        .RST_n     (RST_n),
        .in_valid  (in_valid),
        .op        (op),
        .is_mul    (is_mul),
        .a         (a),
        .b         (b),
        .stall     (stall),
        .out_valid (out_valid),
        .result    (result)
    );

    always #2 clk = ~clk;

    function automatic exec_pkg::word_t expected_result(input logic [3:0] code,
                                                        input logic mul,
                                                        input exec_pkg::word_t x,
                                                        input exec_pkg::word_t y);
        logic [63:0]     full;
        logic [63:0]     ext;
        int unsigned     sh;
        exec_pkg::word_t res;
        full = {32'd0, x} * {32'd0, y};
        sh   = 32'(y[4:0]);                // Only the low five bits shift
        ext  = {{32{x[31]}}, x} >> sh;     // Sign copies drop into the low word
        case (code)
            exec_pkg::ADD: res = x + y;
            exec_pkg::SUB: res = x - y;
            exec_pkg::SLT: res = ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            exec_pkg::SLL: res = x << sh;
            exec_pkg::SRL: res = x >> sh;
            exec_pkg::SRA: res = ext[31:0];
            exec_pkg::XOR: res = x ^ y;
            exec_pkg::OR:  res = x | y;
            default:       res = x & y;
        endcase
        if (mul) begin
            res = full[31:0];   // Low half of the product
        end
        return res;
    endfunction

    task automatic check_value(input string name, input exec_pkg::word_t expected,
                               input exec_pkg::word_t actual);
        checks++;
        if (actual !== expected) begin
            value_errors++;
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic report_problem(input string msg);
        other_errors++;
        $display("%s", msg);
    endtask

    task automatic drop_front();
        void'(name_q.pop_front());
        void'(value_q.pop_front());
        void'(edge_q.pop_front());
    endtask

    task automatic issue_op(input string name, input logic mul, input int code,
                            input exec_pkg::word_t x, input exec_pkg::word_t y,
                            input logic stall_v);
        @(posedge clk);
        #1;
        cur_test = name;
        in_valid = 1'b1;
        is_mul   = mul;
        op       = exec_pkg::alu_op_t'(4'(code));
        a        = x;
        b        = y;
        stall    = stall_v;
    endtask

    task automatic idle_cycle(input logic stall_v);
        @(posedge clk);
        #1;
        cur_test = "bubble";
        in_valid = 1'b0;
        stall    = stall_v;
    endtask

    task automatic random_cycle(input string name, input logic stall_v);
        int unsigned pick;
        int          code;
        pick = $urandom % 8;
        code = int'($urandom % 10);
        if (code == 9) begin
            code = 13;   // Undefined code
        end
        if (pick < 2) begin
            idle_cycle(stall_v);
        end else begin
            issue_op(name, pick < 4, code, $urandom(), $urandom(), stall_v);
        end
    endtask

    // What the DUT accepts at each rising edge
    always @(posedge clk) begin
        if (RST_n) begin
            edge_seen    = 1'b1;
            edge_stalled = stall;
            if (!stall) begin
                live_edges++;
                if (in_valid) begin
                    name_q.push_back(cur_test);
                    value_q.push_back(expected_result(op, is_mul, a, b));
                    edge_q.push_back(live_edges);
                end
            end
        end
    end

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (edge_seen) begin
            if (edge_stalled) begin
                check_value("stall holds out_valid", 32'(prev_valid), 32'(out_valid));
                check_value("stall holds result", prev_result, result);
            end else if (out_valid) begin
                if (value_q.size() == 0) begin
                    report_problem($sformatf("out_valid after edge %0d with nothing in flight",
                                             live_edges));
                end else begin
                    check_value(name_q[0], value_q[0], result);
                    if (edge_q[0] + exec_pkg::PIPE_DEPTH != live_edges) begin
                        report_problem($sformatf("%s came out after edge %0d instead of %0d",
                                                 name_q[0], live_edges,
                                                 edge_q[0] + exec_pkg::PIPE_DEPTH));
                    end
                    drop_front();
                end
            end else if (value_q.size() != 0 &&
                         edge_q[0] + exec_pkg::PIPE_DEPTH <= live_edges) begin
                report_problem($sformatf("%s did not come out after edge %0d",
                                         name_q[0], live_edges));
                drop_front();
            end
            prev_valid  = out_valid;
            prev_result = result;
        end
    end

    initial begin : main
        exec_pkg::word_t dir_a   [8];
        exec_pkg::word_t dir_b   [8];
        exec_pkg::word_t corners [6];
        int              code;
        int unsigned     drain_cycles;
        clk          = 1'b0;
        RST_n        = 1'b0;
        in_valid     = 1'b0;
        op           = exec_pkg::ADD;
        is_mul       = 1'b0;
        a            = '0;
        b            = '0;
        stall        = 1'b0;
        cur_test     = "bubble";
        live_edges   = 0;
        edge_seen    = 1'b0;
        edge_stalled = 1'b0;
        prev_valid   = 1'b0;
        prev_result  = '0;
        checks       = 0;
        value_errors = 0;
        other_errors = 0;
        void'($urandom(51735));

        // Mixed signs, shifts above 31 and a negative a for SRA
        dir_a = '{32'h0000_0005, 32'hffff_fffb, 32'h0000_0003, 32'h8000_0000,
                  32'h7fff_ffff, 32'hf0f0_1234, 32'h8765_4321, 32'h8000_0001};
        dir_b = '{32'h0000_0003, 32'h0000_0003, 32'hffff_fffb, 32'h7fff_ffff,
                  32'h8000_0000, 32'h0000_0025, 32'hffff_ffe1, 32'h0000_001f};
        corners = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff, 32'h0};
        corners[5] = $urandom();

        repeat (2) begin
            @(posedge clk);
            #1;
            check_value("reset out_valid", 32'd0, 32'(out_valid));
            check_value("reset result", 32'd0, result);
        end
        RST_n = 1'b1;
        @(posedge clk);
        #1;
        check_value("first cycle out_valid", 32'd0, 32'(out_valid));
        check_value("first cycle result", 32'd0, result);

        for (int k = 0; k < 10; k++) begin
            code = (k == 9) ? 12 : k;
            for (int i = 0; i < 8; i++) begin
                issue_op($sformatf("alu op %0d directed %0d", code, i), 1'b0, code,
                         dir_a[i], dir_b[i], 1'b0);
            end
            for (int i = 0; i < 8; i++) begin
                issue_op($sformatf("alu op %0d random %0d", code, i), 1'b0, code,
                         $urandom(), $urandom(), 1'b0);
            end
        end

        for (int i = 0; i < 6; i++) begin
            for (int j = 0; j < 6; j++) begin
                issue_op($sformatf("mul %h * %h", corners[i], corners[j]), 1'b1, 0,
                         corners[i], corners[j], 1'b0);
            end
        end

        repeat (200) random_cycle("order", 1'b0);                     // Bubbles only
        repeat (300) random_cycle("stall", ($urandom % 3) == 0);      // Random freezes

        idle_cycle(1'b0);
        drain_cycles = 0;
        while (value_q.size() != 0 && drain_cycles < DRAIN_LIMIT) begin
            @(posedge clk);
            #1;
            drain_cycles++;
        end
        if (value_q.size() != 0) begin
            report_problem($sformatf("Timeout with %0d results still in flight",
                                     value_q.size()));
        end
        repeat (4) idle_cycle(1'b0);   // An extra out_valid would show here

        $display("Checks: %0d, value mismatches: %0d, other errors: %0d",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: exec_unit.f
exec_pkg.sv
alu.sv
booth_encoder.sv
csa_layer.sv
booth_multiplier.sv
exec_unit.sv
exec_unit_tb.sv

// File: Makefile
TOP = exec_unit_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build output and the log"
	@echo "  help   list these targets"

test:
	verilator --binary -j 0 -Wno-fatal --top-module $(TOP) -f exec_unit.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
